// ==== design/ci_pkg.sv ====
package ci_pkg;

    // pixel and median width
    localparam int PIX_W = 8;

    // frame geometry, one window per position
    localparam int COLS = 11;
    localparam int ROWS = 11;
    localparam int NPIX = COLS * ROWS;

    // window counter, must reach NPIX-1
    localparam int CNT_W = $clog2(NPIX);

    // accumulator holds NPIX full-scale medians
    localparam int SUM_W = $clog2(NPIX * ((1 << PIX_W) - 1) + 1);

    // median9 pipeline depth
    localparam int MED_LAT = 3;

    // divider step counter, counts 0 .. SUM_W-1
    localparam int BIT_W = $clog2(SUM_W);

    // frame_ctrl pass states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [ST_W-1:0] ST_PASS1 = 2'd1;
    localparam logic [ST_W-1:0] ST_WAIT  = 2'd2;
    localparam logic [ST_W-1:0] ST_PASS2 = 2'd3;

endpackage

// ==== design/median9.sv ====
module median9 (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [ci_pkg::PIX_W-1:0] s1_i,
    input  logic [ci_pkg::PIX_W-1:0] s2_i,
    input  logic [ci_pkg::PIX_W-1:0] s3_i,
    input  logic [ci_pkg::PIX_W-1:0] s4_i,
    input  logic [ci_pkg::PIX_W-1:0] s5_i,
    input  logic [ci_pkg::PIX_W-1:0] s6_i,
    input  logic [ci_pkg::PIX_W-1:0] s7_i,
    input  logic [ci_pkg::PIX_W-1:0] s8_i,
    input  logic [ci_pkg::PIX_W-1:0] s9_i,
    output logic [ci_pkg::PIX_W-1:0] med_o
);

    // stage 1, each row sorted
    logic [ci_pkg::PIX_W-1:0] lo_q [3];
    logic [ci_pkg::PIX_W-1:0] md_q [3];
    logic [ci_pkg::PIX_W-1:0] hi_q [3];

    // stage 2, the three candidates
    logic [ci_pkg::PIX_W-1:0] max_lo_q;
    logic [ci_pkg::PIX_W-1:0] med_md_q;
    logic [ci_pkg::PIX_W-1:0] min_hi_q;

    function automatic logic [ci_pkg::PIX_W-1:0] max2(
        input logic [ci_pkg::PIX_W-1:0] a,
        input logic [ci_pkg::PIX_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    function automatic logic [ci_pkg::PIX_W-1:0] min2(
        input logic [ci_pkg::PIX_W-1:0] a,
        input logic [ci_pkg::PIX_W-1:0] b
    );
        return (a < b) ? a : b;
    endfunction

    function automatic logic [ci_pkg::PIX_W-1:0] med3(
        input logic [ci_pkg::PIX_W-1:0] a,
        input logic [ci_pkg::PIX_W-1:0] b,
        input logic [ci_pkg::PIX_W-1:0] c
    );
        return max2(min2(a, b), min2(max2(a, b), c));
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_q <= '{default: '0};
            md_q <= '{default: '0};
            hi_q <= '{default: '0};
        end else begin
            lo_q[0] <= min2(min2(s1_i, s2_i), s3_i); // top row
            md_q[0] <= med3(s1_i, s2_i, s3_i);
            hi_q[0] <= max2(max2(s1_i, s2_i), s3_i);
            lo_q[1] <= min2(min2(s4_i, s5_i), s6_i); // middle row
            md_q[1] <= med3(s4_i, s5_i, s6_i);
            hi_q[1] <= max2(max2(s4_i, s5_i), s6_i);
            lo_q[2] <= min2(min2(s7_i, s8_i), s9_i); // bottom row
            md_q[2] <= med3(s7_i, s8_i, s9_i);
            hi_q[2] <= max2(max2(s7_i, s8_i), s9_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            max_lo_q <= '0;
            med_md_q <= '0;
            min_hi_q <= '0;
        end else begin
            max_lo_q <= max2(max2(lo_q[0], lo_q[1]), lo_q[2]);
            med_md_q <= med3(md_q[0], md_q[1], md_q[2]);
            min_hi_q <= min2(min2(hi_q[0], hi_q[1]), hi_q[2]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            med_o <= '0;
        end else begin
            med_o <= med3(max_lo_q, med_md_q, min_hi_q); // median of all nine
        end
    end

endmodule

// ==== design/frame_ctrl.sv ====
module frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic                     win_valid_i,
    input  logic [ci_pkg::PIX_W-1:0] med_i,
    input  logic                     div_done_i,
    output logic [ci_pkg::SUM_W-1:0] sum_o,
    output logic                     sum_done_o,
    output logic                     cmp_en_o,
    output logic                     done_o
);

    logic [ci_pkg::ST_W-1:0]    state;
    logic [ci_pkg::MED_LAT-1:0] vld_sr;
    logic [ci_pkg::CNT_W-1:0]   cnt;
    logic                       win_take;
    logic                       med_vld;
    logic                       last_win;
    logic                       fin_q;

    // windows count only inside a pass, pass 2 opens with div_done
    assign win_take = win_valid_i &&
                      ((state == ci_pkg::ST_PASS1) ||
                       (state == ci_pkg::ST_PASS2) ||
                       ((state == ci_pkg::ST_WAIT) && div_done_i));

    assign med_vld  = vld_sr[ci_pkg::MED_LAT-1]; // lines up with med_i
    assign last_win = (cnt == ci_pkg::CNT_W'(ci_pkg::NPIX - 1));
    assign cmp_en_o = med_vld && (state == ci_pkg::ST_PASS2);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[ci_pkg::MED_LAT-2:0], win_take};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ci_pkg::ST_IDLE;
            cnt        <= '0;
            sum_o      <= '0;
            sum_done_o <= 1'b0;
            fin_q      <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            sum_done_o <= 1'b0;
            fin_q      <= cmp_en_o && last_win; // last bit being registered
            done_o     <= fin_q;
            case (state)
                ci_pkg::ST_IDLE: begin
                    if (start_i) begin
                        state <= ci_pkg::ST_PASS1;
                        cnt   <= '0;
                        sum_o <= '0;
                    end
                end
                ci_pkg::ST_PASS1: begin
                    if (med_vld) begin
                        sum_o <= sum_o + ci_pkg::SUM_W'(med_i);
                        if (last_win) begin
                            cnt        <= '0;
                            state      <= ci_pkg::ST_WAIT;
                            sum_done_o <= 1'b1; // sum_o final from here
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ci_pkg::ST_WAIT: begin
                    if (div_done_i) begin
                        state <= ci_pkg::ST_PASS2;
                        cnt   <= '0;
                    end
                end
                ci_pkg::ST_PASS2: begin
                    if (med_vld) begin
                        if (last_win) begin
                            cnt   <= '0;
                            state <= ci_pkg::ST_IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= ci_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/mean_div.sv ====
module mean_div (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sum_done_i,
    input  logic [ci_pkg::SUM_W-1:0] sum_i,
    output logic [ci_pkg::PIX_W-1:0] quot_o,
    output logic [ci_pkg::PIX_W-1:0] rem_o,
    output logic                     div_done_o
);

    localparam logic [ci_pkg::PIX_W:0] DIVISOR = (ci_pkg::PIX_W + 1)'(ci_pkg::NPIX);

    logic                     busy;
    logic [ci_pkg::BIT_W-1:0] bit_cnt;
    logic [ci_pkg::SUM_W-1:0] dq_q;    // dividend out at top, quotient in at bottom
    logic [ci_pkg::PIX_W-1:0] part_q;  // partial remainder, always below NPIX
    logic [ci_pkg::PIX_W:0]   trial;
    logic [ci_pkg::PIX_W:0]   diff;
    logic                     take;
    logic [ci_pkg::SUM_W-1:0] dq_nxt;
    logic [ci_pkg::PIX_W-1:0] part_nxt;

    // one restoring step
    assign trial    = {part_q, dq_q[ci_pkg::SUM_W-1]};
    assign diff     = trial - DIVISOR;
    assign take     = (trial >= DIVISOR);
    assign part_nxt = take ? diff[ci_pkg::PIX_W-1:0] : trial[ci_pkg::PIX_W-1:0];
    assign dq_nxt   = {dq_q[ci_pkg::SUM_W-2:0], take};

    always_ff @(posedge clk) begin
        if (busy) begin
            dq_q   <= dq_nxt;
            part_q <= part_nxt;
        end else if (sum_done_i) begin
            dq_q   <= sum_i;
            part_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            bit_cnt    <= '0;
            quot_o     <= '0;
            rem_o      <= '0;
            div_done_o <= 1'b0;
        end else begin
            div_done_o <= 1'b0;
            if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == ci_pkg::BIT_W'(ci_pkg::SUM_W - 1)) begin
                    busy       <= 1'b0;
                    quot_o     <= dq_nxt[ci_pkg::PIX_W-1:0]; // upper bits are zero
                    rem_o      <= part_nxt;
                    div_done_o <= 1'b1;
                end
            end else if (sum_done_i) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
        end
    end

endmodule

// ==== design/ci_thresh.sv ====
module ci_thresh (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     div_done_i,
    input  logic [ci_pkg::PIX_W-1:0] quot_i,
    input  logic [ci_pkg::PIX_W-1:0] rem_i,
    input  logic                     cmp_en_i,
    input  logic [ci_pkg::PIX_W-1:0] med_i,
    output logic                     ci_o,
    output logic                     ci_valid_o
);

    logic [ci_pkg::PIX_W-1:0] mean_q;
    logic                     rem_zero_q;
    logic                     ci_bit;

    // above the mean, or exactly on an integer mean
    assign ci_bit = (med_i > mean_q) || ((med_i == mean_q) && rem_zero_q);

    // mean hold register, stable for the whole of pass 2
    always_ff @(posedge clk) begin
        if (rst) begin
            mean_q     <= '0;
            rem_zero_q <= 1'b0;
        end else if (div_done_i) begin
            mean_q     <= quot_i;
            rem_zero_q <= (rem_i == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ci_o       <= 1'b0;
            ci_valid_o <= 1'b0;
        end else begin
            ci_valid_o <= cmp_en_i;
            if (cmp_en_i) begin
                ci_o <= ci_bit;
            end
        end
    end

endmodule

// ==== design/ci_r4_top.sv ====
module ci_r4_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  logic                     win_valid_i,
    input  logic [ci_pkg::PIX_W-1:0] s1_i,
    input  logic [ci_pkg::PIX_W-1:0] s2_i,
    input  logic [ci_pkg::PIX_W-1:0] s3_i,
    input  logic [ci_pkg::PIX_W-1:0] s4_i,
    input  logic [ci_pkg::PIX_W-1:0] s5_i,
    input  logic [ci_pkg::PIX_W-1:0] s6_i,
    input  logic [ci_pkg::PIX_W-1:0] s7_i,
    input  logic [ci_pkg::PIX_W-1:0] s8_i,
    input  logic [ci_pkg::PIX_W-1:0] s9_i,
    output logic                     ci_o,
    output logic                     ci_valid_o,
    output logic                     mean_ready_o,
    output logic                     done_o
);

    logic [ci_pkg::PIX_W-1:0] med;
    logic [ci_pkg::SUM_W-1:0] sum;
    logic                     sum_done;
    logic [ci_pkg::PIX_W-1:0] quot;
    logic [ci_pkg::PIX_W-1:0] rem;
    logic                     div_done;
    logic                     cmp_en;

    assign mean_ready_o = div_done; // host may start pass 2

    median9 u_median (
        .clk   (clk),
        .rst   (rst),
        .s1_i  (s1_i),
        .s2_i  (s2_i),
        .s3_i  (s3_i),
        .s4_i  (s4_i),
        .s5_i  (s5_i),
        .s6_i  (s6_i),
        .s7_i  (s7_i),
        .s8_i  (s8_i),
        .s9_i  (s9_i),
        .med_o (med)
    );

    frame_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .win_valid_i (win_valid_i),
        .med_i       (med),
        .div_done_i  (div_done),
        .sum_o       (sum),
        .sum_done_o  (sum_done),
        .cmp_en_o    (cmp_en),
        .done_o      (done_o)
    );

    mean_div u_div (
        .clk        (clk),
        .rst        (rst),
        .sum_done_i (sum_done),
        .sum_i      (sum),
        .quot_o     (quot),
        .rem_o      (rem),
        .div_done_o (div_done)
    );

    ci_thresh u_thresh (
        .clk        (clk),
        .rst        (rst),
        .div_done_i (div_done),
        .quot_i     (quot),
        .rem_i      (rem),
        .cmp_en_i   (cmp_en),
        .med_i      (med),
        .ci_o       (ci_o),
        .ci_valid_o (ci_valid_o)
    );

endmodule

// ==== bench/tb_ci_r4.sv ====
module tb_ci_r4;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NFRM = 5;
    localparam int TMO  = 100; // cycles allowed per wait

    typedef struct packed {
        logic [1:0] mode;      // 0 lfsr, 1 constant, 2 masked lfsr
        logic [7:0] base;
        logic [7:0] mask;
        logic [7:0] gap_every; // 0 is continuous
        logic [7:0] gap_len;
        logic [7:0] early;     // pass-2 windows sent before mean_ready_o
        logic       need_eq;   // frame must hit median == mean with remainder
    } frame_t;

    logic clk = 1'b0;
    logic rst, start, win_valid;
    logic [ci_pkg::PIX_W-1:0] pix [9];
    logic ci_o, ci_valid_o, mean_ready_o, done_o;

    frame_t tab [NFRM];
    logic [31:0] lfsr;
    logic [ci_pkg::PIX_W-1:0] win [ci_pkg::NPIX][9];
    logic [ci_pkg::PIX_W-1:0] med [ci_pkg::NPIX];
    logic exp_ci [ci_pkg::NPIX];
    int exp_quot, exp_rem, eq_nz;
    int cyc = 0;
    int last_edge, mr_cnt, mr_cyc, done_cnt, done_cyc;
    int checks, errors, timeouts;
    bit abort;
    logic ci_val_q [$];
    int ci_cyc_q [$];
    int drv_q [$];

    ci_r4_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .win_valid_i  (win_valid),
        .s1_i         (pix[0]),
        .s2_i         (pix[1]),
        .s3_i         (pix[2]),
        .s4_i         (pix[3]),
        .s5_i         (pix[4]),
        .s6_i         (pix[5]),
        .s7_i         (pix[6]),
        .s8_i         (pix[7]),
        .s9_i         (pix[8]),
        .ci_o         (ci_o),
        .ci_valid_o   (ci_valid_o),
        .mean_ready_o (mean_ready_o),
        .done_o       (done_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1; // edge index

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (ci_valid_o) begin
            ci_val_q.push_back(ci_o);
            ci_cyc_q.push_back(cyc);
        end
        if (mean_ready_o) begin
            mr_cnt++;
            mr_cyc = cyc;
        end
        if (done_o) begin
            done_cnt++;
            done_cyc = cyc;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_step(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] median_of(input int w);
        logic [7:0] v [9];
        logic [7:0] t;
        int j;
        for (int i = 0; i < 9; i++) v[i] = win[w][i];
        for (int i = 1; i < 9; i++) begin // insertion sort
            t = v[i];
            j = i - 1;
            while (j >= 0 && v[j] > t) begin
                v[j+1] = v[j];
                j--;
            end
            v[j+1] = t;
        end
        return v[4];
    endfunction

    task automatic build_frame(input int f);
        logic [7:0] b;
        int s;
        s = 0;
        eq_nz = 0;
        for (int w = 0; w < ci_pkg::NPIX; w++) begin
            for (int k = 0; k < 9; k++) begin
                case (tab[f].mode)
                    2'd1: win[w][k] = tab[f].base;
                    2'd2: begin
                        next_byte(b);
                        win[w][k] = tab[f].base + (b & tab[f].mask);
                    end
                    default: begin
                        next_byte(b);
                        win[w][k] = b;
                    end
                endcase
            end
            med[w] = median_of(w);
            s += med[w];
        end
        exp_quot = s / ci_pkg::NPIX;
        exp_rem  = s % ci_pkg::NPIX;
        for (int w = 0; w < ci_pkg::NPIX; w++) begin
            exp_ci[w] = (med[w] > exp_quot) || (med[w] == exp_quot && exp_rem == 0);
            if (med[w] == exp_quot && exp_rem != 0) eq_nz++;
        end
    endtask

    task automatic check_val(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles", what, TMO);
        timeouts++;
        abort = 1'b1;
    endtask

    task automatic put_window(input int w, input bit junk);
        start     <= 1'b0;
        win_valid <= 1'b1;
        for (int k = 0; k < 9; k++) pix[k] <= junk ? 8'hff : win[w][k];
    endtask

    task automatic send_pass(input int f, input bit record);
        for (int i = 0; i < ci_pkg::NPIX; i++) begin
            @(posedge clk);
            put_window(i, 1'b0);
            last_edge = cyc + 1;
            if (record) drv_q.push_back(cyc + 1);
            if (tab[f].gap_every != 0 && (i + 1) % tab[f].gap_every == 0) begin
                repeat (tab[f].gap_len) begin
                    @(posedge clk);
                    win_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        win_valid <= 1'b0;
    endtask

    task automatic run_frame(input int f);
        int t, mr0, dn0, p1_last;
        build_frame(f);
        ci_val_q.delete();
        ci_cyc_q.delete();
        drv_q.delete();
        mr0 = mr_cnt;
        dn0 = done_cnt;
        @(posedge clk);
        start <= 1'b1;
        send_pass(f, 1'b0);
        p1_last = last_edge;
        repeat (18 - tab[f].early) @(posedge clk); // last early window just before mean_ready_o
        for (int k = 0; k < tab[f].early; k++) begin
            @(posedge clk);
            put_window(0, 1'b1); // must be dropped
        end
        @(posedge clk);
        win_valid <= 1'b0;
        t = 0;
        while (mr_cnt == mr0 && t < TMO) begin
            @(posedge clk);
            t++;
        end
        if (mr_cnt == mr0) begin
            note_timeout("mean_ready_o");
            return;
        end
        check_val("mean_ready_o latency", mr_cyc - p1_last, 20);
        check_val("ci_valid_o pulses before pass 2", ci_val_q.size(), 0);
        send_pass(f, 1'b1);
        for (int i = 0; i < ci_pkg::NPIX; i++) begin
            t = 0;
            while (ci_val_q.size() <= i && t < TMO) begin
                @(posedge clk);
                t++;
            end
            if (ci_val_q.size() <= i) begin
                note_timeout($sformatf("ci_valid_o for window %0d", i));
                return;
            end
            check_val($sformatf("ci_o frame %0d window %0d", f, i), ci_val_q[i], exp_ci[i]);
            check_val("ci_valid_o latency", ci_cyc_q[i] - drv_q[i], 4);
        end
        t = 0;
        while (done_cnt == dn0 && t < TMO) begin
            @(posedge clk);
            t++;
        end
        if (done_cnt == dn0) begin
            note_timeout("done_o");
            return;
        end
        repeat (8) @(posedge clk);
        check_val("done_o pulses", done_cnt - dn0, 1);
        check_val("done_o after last ci_valid_o", done_cyc - ci_cyc_q[ci_pkg::NPIX-1], 1);
        check_val("ci_valid_o pulses", ci_val_q.size(), ci_pkg::NPIX);
        if (tab[f].need_eq) check_val("equal median with remainder cases", eq_nz > 0, 1);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        win_valid = 1'b0;
        for (int k = 0; k < 9; k++) pix[k] = '0;
        lfsr = 32'h2c30;
        mr_cnt = 0;
        done_cnt = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        abort = 1'b0;
        tab[0] = '{2'd0, 8'd0,   8'hff, 8'd0, 8'd0, 8'd0, 1'b0};
        tab[1] = '{2'd1, 8'd77,  8'h00, 8'd0, 8'd0, 8'd0, 1'b0}; // integer mean
        tab[2] = '{2'd2, 8'd100, 8'h03, 8'd0, 8'd0, 8'd0, 1'b1};
        tab[3] = '{2'd0, 8'd0,   8'hff, 8'd7, 8'd2, 8'd3, 1'b0};
        tab[4] = '{2'd2, 8'd40,  8'h3f, 8'd3, 8'd1, 8'd2, 1'b0};
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_val("ci_valid_o after reset", ci_valid_o, 0);
        check_val("done_o after reset", done_o, 0);
        check_val("mean_ready_o after reset", mean_ready_o, 0);
        check_val("output pulses before start", ci_val_q.size() + mr_cnt + done_cnt, 0);
        for (int f = 0; f < NFRM && !abort; f++) run_frame(f);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/ci_pkg.sv
design/median9.sv
design/frame_ctrl.sv
design/mean_div.sv
design/ci_thresh.sv
design/ci_r4_top.sv
bench/tb_ci_r4.sv

// ==== Bender.yml ====
package:
  name: ci_r4

sources:
  - design/ci_pkg.sv
  - design/median9.sv
  - design/frame_ctrl.sv
  - design/mean_div.sv
  - design/ci_thresh.sv
  - design/ci_r4_top.sv
  - target: simulation
    files:
      - bench/tb_ci_r4.sv
